// File: src/aznable_pkg.sv
package aznable_pkg;

	// request from the external bus master
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic we;
		logic req;
	} bus_req_t;

	// response back to the bus master
	typedef struct packed {
		logic [7:0] rdata;
		logic ack;
	} bus_rsp_t;

	// one 24-bit pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// pixel from a layer, a marks it opaque
	typedef struct packed {
		rgb_t rgb;
		logic a;
	} layer_px_t;

	// raster position and timing from the raster timer
	typedef struct packed {
		logic [8:0] hcnt;
		logic [8:0] vcnt;
		logic pix_en;
		logic hblank;
		logic vblank;
		logic hsync;
		logic vsync;
	} raster_t;

	// input status byte, msb first
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
		// always 2'b10 so software can spot the port
		logic [1:0] id;
		logic menu;
		logic debug;
	} in0_fields_t;

	// same status byte seen as fields or as a raw byte
	typedef union packed {
		in0_fields_t f;
		logic [7:0] b;
	} in0_word_u;

	// memory map
	localparam logic [15:0] ADDR_IN0 = 16'h8000;
	localparam logic [15:0] ADDR_VIDEO_CTL = 16'h8001;
	// timer page, matched on addr[15:8]
	localparam logic [7:0] ADDR_TIMER_PAGE = 8'h89;
	localparam logic [15:0] ADDR_PAUSE = 16'h8A30;
	localparam logic [15:0] ADDR_MENU = 16'h8A31;
	// work ram fills c000-ffff, mirrored by its size
	localparam logic [15:0] ADDR_WKRAM_BASE = 16'hC000;

endpackage

// File: src/raster_timer.sv
`timescale 1ns/1ps

module raster_timer #(
	parameter int H_TOTAL = 396,
	parameter int V_TOTAL = 256,
	parameter int H_VISIBLE = 320,
	parameter int V_VISIBLE = 240
) (
	input logic clk_24,
	input logic rst_n,
	output aznable_pkg::raster_t raster
);
	import aznable_pkg::*;

	// sync pulses sit in the middle of each blanked region
	localparam int HS_START = H_VISIBLE + (H_TOTAL - H_VISIBLE) / 4;
	localparam int HS_END = HS_START + (H_TOTAL - H_VISIBLE) / 2;
	localparam int VS_START = V_VISIBLE + (V_TOTAL - V_VISIBLE) / 4;
	localparam int VS_END = VS_START + (V_TOTAL - V_VISIBLE) / 2;

	logic [1:0] div;
	logic pix_en;
	logic [8:0] hcnt;
	logic [8:0] vcnt;

	// 24 MHz divided by four gives the pixel rate
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			div <= 2'd0;
		else
			div <= div + 2'd1;
	end

	assign pix_en = div == 2'd3;

	// hcnt steps per pixel, vcnt steps per line
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			hcnt <= 9'd0;
			vcnt <= 9'd0;
		end
		else if (pix_en)
		begin
			if (hcnt == 9'(H_TOTAL - 1))
			begin
				hcnt <= 9'd0;
				// end of line, move down or back to the top
				if (vcnt == 9'(V_TOTAL - 1))
					vcnt <= 9'd0;
				else
					vcnt <= vcnt + 9'd1;
			end
			else
				hcnt <= hcnt + 9'd1;
		end
	end

	always_comb
	begin
		raster.hcnt = hcnt;
		raster.vcnt = vcnt;
		raster.pix_en = pix_en;
		// blanking from the visible limits onwards
		raster.hblank = hcnt >= 9'(H_VISIBLE);
		raster.vblank = vcnt >= 9'(V_VISIBLE);
		raster.hsync = (hcnt >= 9'(HS_START)) && (hcnt < 9'(HS_END));
		raster.vsync = (vcnt >= 9'(VS_START)) && (vcnt < 9'(VS_END));
	end

	// counters never leave the raster
	hcnt_in_range: assert property (@(posedge clk_24) disable iff (!rst_n)
		(hcnt < 9'(H_TOTAL)) && (vcnt < 9'(V_TOTAL)));

endmodule

// File: src/bus_regs.sv
`timescale 1ns/1ps

module bus_regs #(
	parameter int TIMER_DIV = 24000,
	parameter int WKRAM_AW = 8
) (
	input logic clk_24,
	input logic rst_n,
	input aznable_pkg::bus_req_t bus_req,
	output aznable_pkg::bus_rsp_t bus_rsp,
	input aznable_pkg::raster_t raster,
	input logic pause,
	input logic menu,
	output logic sprite_high,
	output logic pause_sys
);
	import aznable_pkg::*;

	localparam int PRE_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

	logic ack;
	logic [7:0] rdata;
	logic access;
	logic wr;
	logic in0_cs;
	logic video_ctl_cs;
	logic timer_cs;
	logic pause_cs;
	logic menu_cs;
	logic wkram_cs;
	logic [WKRAM_AW-1:0] wkram_addr;
	logic [7:0] wkram [2**WKRAM_AW];
	logic [7:0] video_control;
	logic pause_trigger;
	logic menu_trigger;
	logic [PRE_W-1:0] prescale;
	logic [15:0] timer;
	in0_word_u in0_word;
	logic [7:0] reg_rdata;

	// an access happens once, on the first cycle req is seen without ack
	assign access = bus_req.req && !ack;
	assign wr = access && bus_req.we;

	// address decode
	assign in0_cs = bus_req.addr == ADDR_IN0;
	assign video_ctl_cs = bus_req.addr == ADDR_VIDEO_CTL;
	assign timer_cs = bus_req.addr[15:8] == ADDR_TIMER_PAGE;
	assign pause_cs = bus_req.addr == ADDR_PAUSE;
	assign menu_cs = bus_req.addr == ADDR_MENU;
	assign wkram_cs = bus_req.addr[15:14] == ADDR_WKRAM_BASE[15:14];
	// small ram, mirrored over the whole window
	assign wkram_addr = bus_req.addr[WKRAM_AW-1:0];

	// four-phase handshake
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			ack <= 1'b0;
		else if (access)
			ack <= 1'b1;
		else if (!bus_req.req)
			ack <= 1'b0;
	end

	// video control and system triggers
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			video_control <= 8'h00;
			pause_trigger <= 1'b0;
			menu_trigger <= 1'b0;
		end
		else
		begin
			if (wr && video_ctl_cs)
				video_control <= bus_req.wdata;
			// pause input wins over a software pause request
			if (wr && pause_cs)
				pause_trigger <= 1'b1;
			if (pause)
				pause_trigger <= 1'b0;
			// software clear wins over the menu input
			if (menu)
				menu_trigger <= 1'b1;
			if (wr && menu_cs)
				menu_trigger <= 1'b0;
		end
	end

	// millisecond timer, any write in its page restarts it
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			prescale <= '0;
			timer <= 16'd0;
		end
		else if (wr && timer_cs)
		begin
			prescale <= '0;
			timer <= 16'd0;
		end
		else if (prescale == PRE_W'(TIMER_DIV - 1))
		begin
			prescale <= '0;
			timer <= timer + 16'd1;
		end
		else
			prescale <= prescale + 1'b1;
	end

	// status byte as the cpu sees it
	always_comb
	begin
		in0_word.f.hsync = raster.hsync;
		in0_word.f.vsync = raster.vsync;
		in0_word.f.hblank = raster.hblank;
		in0_word.f.vblank = raster.vblank;
		in0_word.f.id = 2'b10;
		in0_word.f.menu = menu_trigger;
		in0_word.f.debug = 1'b0;
	end

	// register read mux, unmapped reads give 0
	always_comb
	begin
		reg_rdata = 8'h00;
		if (in0_cs)
			reg_rdata = in0_word.b;
		else if (video_ctl_cs)
			reg_rdata = video_control;
		else if (timer_cs && (bus_req.addr[7:1] == 7'd0))
			reg_rdata = bus_req.addr[0] ? timer[15:8] : timer[7:0];
		else if (menu_cs)
			reg_rdata = {8{menu_trigger}};
	end

	// work ram and read data, captured with the access
	always_ff @(posedge clk_24)
	begin
		if (wr && wkram_cs)
			wkram[wkram_addr] <= bus_req.wdata;
		if (access)
			rdata <= wkram_cs ? wkram[wkram_addr] : reg_rdata;
	end

	assign bus_rsp.rdata = rdata;
	assign bus_rsp.ack = ack;
	assign sprite_high = video_control[0];
	assign pause_sys = pause || pause_trigger;

	// master keeps req up until it has seen ack
	req_held_for_ack: assert property (@(posedge clk_24) disable iff (!rst_n)
		$fell(bus_req.req) |-> ack);

	// address stays put for the whole request
	addr_stable: assert property (@(posedge clk_24) disable iff (!rst_n)
		bus_req.req && $past(bus_req.req) |-> $stable(bus_req.addr));

endmodule

// File: src/starfield_layer.sv
`timescale 1ns/1ps

module starfield_layer #(
	parameter int LEN = 22,
	parameter logic [LEN-1:0] SEED = 22'h1FFFFF,
	parameter logic [LEN-1:0] MASK = 22'b0000111100001111000011,
	parameter logic [LEN-1:0] TAPS = 22'b1100000000000000000000
) (
	input logic clk_24,
	input logic rst_n,
	input aznable_pkg::raster_t raster,
	input logic pause,
	output aznable_pkg::layer_px_t star
);
	import aznable_pkg::*;

	logic [LEN-1:0] lfsr;
	logic vblank_q;
	logic feedback;
	logic star_on;

	// fibonacci feedback from the tap positions
	assign feedback = ^(lfsr & TAPS);
	// star where every mask bit is set
	assign star_on = (lfsr & MASK) == MASK;

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			lfsr <= SEED;
			vblank_q <= 1'b0;
			star <= '0;
		end
		else
		begin
			vblank_q <= raster.vblank;
			// same seed every frame, so the field repeats
			if (raster.vblank && !vblank_q)
				lfsr <= SEED;
			else if (raster.pix_en && !pause)
				lfsr <= {lfsr[LEN-2:0], feedback};
			// pixel out one clock after pix_en
			if (raster.pix_en)
			begin
				star.a <= star_on;
				star.rgb.r <= lfsr[7:0];
				star.rgb.g <= lfsr[7:0];
				star.rgb.b <= lfsr[7:0];
			end
		end
	end

endmodule

// File: src/layer_mixer.sv
`timescale 1ns/1ps

module layer_mixer (
	input logic clk_24,
	input logic rst_n,
	input aznable_pkg::raster_t raster,
	input logic sprite_high,
	input aznable_pkg::layer_px_t sprite_px,
	input aznable_pkg::layer_px_t char_px,
	input aznable_pkg::layer_px_t star_a,
	input aznable_pkg::layer_px_t star_b,
	output aznable_pkg::rgb_t video_rgb
);
	import aznable_pkg::*;

	logic blank_q;
	logic sprite_high_q;
	layer_px_t sprite_q;
	layer_px_t char_q;
	layer_px_t top_px;
	layer_px_t second_px;
	rgb_t star_b_dim;
	rgb_t mix;

	// first stage lines sprite, char and blanking up with the stars
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			blank_q <= 1'b1;
			sprite_high_q <= 1'b0;
		end
		else
		begin
			blank_q <= raster.hblank || raster.vblank;
			sprite_high_q <= sprite_high;
		end
	end

	always_ff @(posedge clk_24)
	begin
		sprite_q <= sprite_px;
		char_q <= char_px;
	end

	// sprite over charmap when sprite_high is set
	assign top_px = sprite_high_q ? sprite_q : char_q;
	assign second_px = sprite_high_q ? char_q : sprite_q;

	// back star layer at half brightness
	assign star_b_dim.r = {1'b0, star_b.rgb.r[7:1]};
	assign star_b_dim.g = {1'b0, star_b.rgb.g[7:1]};
	assign star_b_dim.b = {1'b0, star_b.rgb.b[7:1]};

	always_comb
	begin
		if (top_px.a)
			mix = top_px.rgb;
		else if (second_px.a)
			mix = second_px.rgb;
		else if (star_a.a)
			mix = star_a.rgb;
		else if (star_b.a)
			mix = star_b_dim;
		else
			mix = '0;
	end

	// black outside the visible area
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			video_rgb <= '0;
		else
			video_rgb <= blank_q ? '0 : mix;
	end

endmodule

// File: src/aznable_video_core.sv
`timescale 1ns/1ps

module aznable_video_core #(
	parameter int H_TOTAL = 396,
	parameter int V_TOTAL = 256,
	parameter int H_VISIBLE = 320,
	parameter int V_VISIBLE = 240,
	parameter int TIMER_DIV = 24000,
	parameter int WKRAM_AW = 8,
	parameter int STAR_A_LEN = 22,
	parameter logic [STAR_A_LEN-1:0] STAR_A_SEED = 22'h1FFFFF,
	parameter logic [STAR_A_LEN-1:0] STAR_A_MASK = 22'b0000111100001111000011,
	parameter logic [STAR_A_LEN-1:0] STAR_A_TAPS = 22'b1100000000000000000000,
	parameter int STAR_B_LEN = 21,
	parameter logic [STAR_B_LEN-1:0] STAR_B_SEED = 21'h1FFFF0,
	parameter logic [STAR_B_LEN-1:0] STAR_B_MASK = 21'b000011110000111100001,
	parameter logic [STAR_B_LEN-1:0] STAR_B_TAPS = 21'b101000000000000000000
) (
	input logic clk_24,
	input logic rst_n,
	input aznable_pkg::bus_req_t bus_req,
	output aznable_pkg::bus_rsp_t bus_rsp,
	input logic pause,
	input logic menu,
	input aznable_pkg::layer_px_t sprite_px,
	input aznable_pkg::layer_px_t char_px,
	output aznable_pkg::rgb_t video_rgb,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank
);
	import aznable_pkg::*;

	raster_t raster;
	logic sprite_high;
	logic pause_sys;
	layer_px_t star_a;
	layer_px_t star_b;

	// raster counters, blanking and syncs
	raster_timer #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL),
		.H_VISIBLE(H_VISIBLE),
		.V_VISIBLE(V_VISIBLE)
	) u_raster_timer (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.raster(raster)
	);

	// cpu side registers, timer and work ram
	bus_regs #(
		.TIMER_DIV(TIMER_DIV),
		.WKRAM_AW(WKRAM_AW)
	) u_bus_regs (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.raster(raster),
		.pause(pause),
		.menu(menu),
		.sprite_high(sprite_high),
		.pause_sys(pause_sys)
	);

	// front star layer
	starfield_layer #(
		.LEN(STAR_A_LEN),
		.SEED(STAR_A_SEED),
		.MASK(STAR_A_MASK),
		.TAPS(STAR_A_TAPS)
	) u_star_a (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.raster(raster),
		.pause(pause_sys),
		.star(star_a)
	);

	// back star layer, different sequence
	starfield_layer #(
		.LEN(STAR_B_LEN),
		.SEED(STAR_B_SEED),
		.MASK(STAR_B_MASK),
		.TAPS(STAR_B_TAPS)
	) u_star_b (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.raster(raster),
		.pause(pause_sys),
		.star(star_b)
	);

	layer_mixer u_layer_mixer (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.raster(raster),
		.sprite_high(sprite_high),
		.sprite_px(sprite_px),
		.char_px(char_px),
		.star_a(star_a),
		.star_b(star_b),
		.video_rgb(video_rgb)
	);

	// timing straight from the raster timer
	assign hsync = raster.hsync;
	assign vsync = raster.vsync;
	assign hblank = raster.hblank;
	assign vblank = raster.vblank;

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_24,
	output logic rst_n
);

	// 100 ns period
	initial
	begin
		clk_24 = 1'b0;
		forever #50 clk_24 = ~clk_24;
	end

	// reset held for four rising edges, released away from the edge
	initial
	begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk_24);
		@(negedge clk_24);
		rst_n = 1'b1;
	end

endmodule

// File: verification/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
	parameter int H_TOTAL = 40,
	parameter int V_TOTAL = 20,
	parameter int H_VISIBLE = 32,
	parameter int V_VISIBLE = 16
) (
	input logic clk_24,
	input logic rst_n,
	input aznable_pkg::layer_px_t sprite_px,
	input aznable_pkg::layer_px_t char_px,
	input logic ctl_hi,
	input logic mix_en,
	input logic hsync,
	input logic vsync,
	input logic hblank,
	input logic vblank,
	input aznable_pkg::rgb_t video_rgb
);
	import aznable_pkg::*;

	int errors = 0;
	int test_errs = 0;
	int blank_errs = 0;
	int blank_checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int primed = 0;
	// clocks since reset went away, drives the raster model
	int clk_n = 0;
	int hsync_clks = 0;
	int vsync_clks = 0;

	// two stage copy of what the mixer saw, lined up with video_rgb
	layer_px_t spr_q [2];
	layer_px_t chr_q [2];
	logic hi_q [2];
	logic en_q [2];
	logic blank_q [2];
	logic [24:0] want;
	logic [1:0] blank_m;

	// sprite_high picks the front layer, the other one sits behind it
	// bit 24 says whether a forced layer decides the pixel
	function automatic logic [24:0] expect_mix(input logic hi, input layer_px_t spr,
		input layer_px_t chr);
		layer_px_t front;
		layer_px_t back;
		front = hi ? spr : chr;
		back = hi ? chr : spr;
		if (front.a)
			return {1'b1, front.rgb};
		if (back.a)
			return {1'b1, back.rgb};
		// only stars or black left, not modelled here
		return 25'd0;
	endfunction

	// expected {hblank, vblank} after n clocks, one pixel every four clocks
	function automatic logic [1:0] model_blank(input int n);
		int pix;
		int h;
		int v;
		pix = n / 4;
		h = pix % H_TOTAL;
		v = (pix / H_TOTAL) % V_TOTAL;
		return {h >= H_VISIBLE, v >= V_VISIBLE};
	endfunction

	task automatic note_failure(input string msg);
		$display("ERROR %s", msg);
		errors++;
		test_errs++;
	endtask

	task automatic value_check(input string name, input logic [23:0] exp,
		input logic [23:0] act);
		if (exp !== act)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic range_check(input string name, input int lo, input int hi,
		input int act);
		if ((act < lo) || (act > hi))
		begin
			$display("MISMATCH %s expected %0d..%0d actual %0d", name, lo, hi, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("%s %s (%0d errors)", (test_errs != 0) ? "FAIL" : "PASS", name, test_errs);
		test_errs = 0;
	endtask

	// blanking is watched during every test, so it has its own counters
	task automatic finish_blank_test(input string name);
		tests_run++;
		if (blank_checks == 0)
		begin
			$display("ERROR no blanked pixels were seen");
			errors++;
			blank_errs++;
		end
		if (hsync_clks == 0)
		begin
			$display("ERROR hsync never pulsed");
			errors++;
			blank_errs++;
		end
		if (vsync_clks == 0)
		begin
			$display("ERROR vsync never pulsed");
			errors++;
			blank_errs++;
		end
		if (blank_errs != 0)
			tests_failed++;
		$display("%s %s (%0d errors, %0d pixels)", (blank_errs != 0) ? "FAIL" : "PASS",
			name, blank_errs, blank_checks);
	endtask

	task automatic summary();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	endtask

	// sample on the same edge the dut samples
	always @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			en_q[0] <= 1'b0;
			en_q[1] <= 1'b0;
			blank_q[0] <= 1'b1;
			blank_q[1] <= 1'b1;
			primed <= 0;
			clk_n <= 0;
		end
		else
		begin
			clk_n <= clk_n + 1;
			spr_q[0] <= sprite_px;
			spr_q[1] <= spr_q[0];
			chr_q[0] <= char_px;
			chr_q[1] <= chr_q[0];
			hi_q[0] <= ctl_hi;
			hi_q[1] <= hi_q[0];
			en_q[0] <= mix_en;
			en_q[1] <= en_q[0];
			// blanking of the pixel the mixer is taking in now
			blank_q[0] <= |model_blank(clk_n);
			blank_q[1] <= blank_q[0];
			if (primed < 2)
				primed <= primed + 1;
		end
	end

	// compare half a cycle later, where video_rgb is settled
	always @(negedge clk_24)
	begin
		if (rst_n && (primed == 2))
		begin
			// raster timing against the counter model
			blank_m = model_blank(clk_n);
			if ({hblank, vblank} !== blank_m)
			begin
				$display("MISMATCH raster_blank expected %b actual %b", blank_m,
					{hblank, vblank});
				errors++;
				blank_errs++;
			end
			if (hsync)
			begin
				hsync_clks++;
				if (!blank_m[1])
				begin
					$display("ERROR hsync high outside horizontal blanking");
					errors++;
					blank_errs++;
				end
			end
			if (vsync)
			begin
				vsync_clks++;
				if (!blank_m[0])
				begin
					$display("ERROR vsync high outside vertical blanking");
					errors++;
					blank_errs++;
				end
			end
			if (blank_q[1])
			begin
				blank_checks++;
				if (video_rgb !== 24'd0)
				begin
					$display("MISMATCH blanking expected %h actual %h", 24'd0, video_rgb);
					errors++;
					blank_errs++;
				end
			end
			else if (en_q[1])
			begin
				want = expect_mix(hi_q[1], spr_q[1], chr_q[1]);
				if (want[24])
					value_check("layer_priority", want[23:0], video_rgb);
			end
		end
	end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	import aznable_pkg::*;

	localparam int H_TOT = 40;
	localparam int V_TOT = 20;
	localparam int H_VIS = 32;
	localparam int V_VIS = 16;
	localparam int TDIV = 24;
	// clocks per frame, four clocks per pixel
	localparam int FRAME = H_TOT * V_TOT * 4;
	localparam int BUS_CYC = 8;
	localparam int N_BUS = 64 * 2 + 20;
	localparam int MIX_CYC = 400;
	// four captures, each may wait up to a frame for its start
	localparam int N_FRAMES = 10;
	localparam int TIMER_N = 5;
	localparam int LIMIT = 2 * (N_BUS * BUS_CYC + 2 * MIX_CYC + N_FRAMES * FRAME
		+ TIMER_N * TDIV + 100);

	logic clk_24;
	logic rst_n;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	logic pause;
	logic menu;
	layer_px_t sprite_px;
	layer_px_t char_px;
	rgb_t video_rgb;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;
	logic ctl_hi;
	logic mix_en;
	logic [31:0] rng;
	int cycles = 0;
	logic [23:0] frame_ref [FRAME];
	logic [23:0] frame_cur [FRAME];
	logic [15:0] ram_addr [64];
	logic [7:0] shadow [256];

	tb_clock u_tb_clock (
		.clk_24(clk_24),
		.rst_n(rst_n)
	);

	aznable_video_core #(
		.H_TOTAL(H_TOT),
		.V_TOTAL(V_TOT),
		.H_VISIBLE(H_VIS),
		.V_VISIBLE(V_VIS),
		.TIMER_DIV(TDIV),
		.WKRAM_AW(8)
	) u_aznable_video_core (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.pause(pause),
		.menu(menu),
		.sprite_px(sprite_px),
		.char_px(char_px),
		.video_rgb(video_rgb),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank)
	);

	tb_checker #(
		.H_TOTAL(H_TOT),
		.V_TOTAL(V_TOT),
		.H_VISIBLE(H_VIS),
		.V_VISIBLE(V_VIS)
	) u_tb_checker (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.sprite_px(sprite_px),
		.char_px(char_px),
		.ctl_hi(ctl_hi),
		.mix_en(mix_en),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank),
		.video_rgb(video_rgb)
	);

	// 32-bit lcg, numerical recipes constants
	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// one four-phase transfer, all edges driven on the falling clock
	task automatic bus_access(input logic [15:0] addr, input logic we,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		@(negedge clk_24);
		bus_req.addr = addr;
		bus_req.we = we;
		bus_req.wdata = wdata;
		bus_req.req = 1'b1;
		waited = 0;
		do
		begin
			@(negedge clk_24);
			waited++;
		end while (!bus_rsp.ack && (waited < 32));
		if (!bus_rsp.ack)
			u_tb_checker.note_failure("bus ack never rose");
		rdata = bus_rsp.rdata;
		bus_req.req = 1'b0;
		waited = 0;
		while (bus_rsp.ack && (waited < 32))
		begin
			@(negedge clk_24);
			waited++;
		end
		if (bus_rsp.ack)
			u_tb_checker.note_failure("bus ack never fell after req dropped");
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		bus_access(addr, 1'b1, data, unused);
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		bus_access(addr, 1'b0, 8'h00, data);
	endtask

	// stars reseed at the vblank rising edge, so frames start there
	task automatic capture_frame();
		int waited;
		waited = 0;
		while (vblank && (waited < 2 * FRAME))
		begin
			@(negedge clk_24);
			waited++;
		end
		while (!vblank && (waited < 2 * FRAME))
		begin
			@(negedge clk_24);
			waited++;
		end
		if (!vblank)
			u_tb_checker.note_failure("vblank never rose");
		for (int i = 0; i < FRAME; i++)
		begin
			frame_cur[i] = video_rgb;
			@(negedge clk_24);
		end
	endtask

	function automatic int count_diffs();
		int n;
		n = 0;
		for (int i = 0; i < FRAME; i++)
			if (frame_cur[i] !== frame_ref[i])
				n++;
		return n;
	endfunction

	initial
	begin
		logic [31:0] r;
		logic [7:0] d;
		logic [7:0] hi_byte;
		logic [23:0] lit;
		int lit_n;
		bus_req = '0;
		pause = 1'b0;
		menu = 1'b0;
		sprite_px = '0;
		char_px = '0;
		ctl_hi = 1'b0;
		mix_en = 1'b0;
		rng = 32'h2f0fa008;
		@(posedge rst_n);
		repeat (2) @(negedge clk_24);

		// work ram, random mirrors of the c000 window
		for (int i = 0; i < 64; i++)
		begin
			r = next_rand();
			ram_addr[i] = {2'b11, r[29:16]};
			shadow[ram_addr[i][7:0]] = r[7:0];
			bus_write(ram_addr[i], r[7:0]);
		end
		for (int i = 0; i < 64; i++)
		begin
			bus_read(ram_addr[i], d);
			u_tb_checker.value_check("work_ram", {16'd0, shadow[ram_addr[i][7:0]]}, {16'd0, d});
		end
		u_tb_checker.finish_test("work_ram");

		// layer priority under both sprite_high values
		for (int hi = 1; hi >= 0; hi--)
		begin
			bus_write(ADDR_VIDEO_CTL, 8'(hi));
			repeat (4) @(negedge clk_24);
			ctl_hi = hi[0];
			for (int i = 0; i < MIX_CYC; i++)
			begin
				@(negedge clk_24);
				mix_en = 1'b1;
				r = next_rand();
				sprite_px = {r[23:0], r[24]};
				r = next_rand();
				char_px = {r[23:0], r[25]};
			end
			@(negedge clk_24);
			mix_en = 1'b0;
			sprite_px = '0;
			char_px = '0;
			repeat (3) @(negedge clk_24);
		end
		u_tb_checker.finish_test("layer_priority");

		// two frames in a row with only the stars showing
		capture_frame();
		frame_ref = frame_cur;
		capture_frame();
		if (count_diffs() != 0)
			u_tb_checker.note_failure($sformatf("starfield frames differ at %0d clocks",
				count_diffs()));
		u_tb_checker.finish_test("starfield_repeat");
		u_tb_checker.finish_blank_test("blanking");

		// menu trigger and status byte
		@(negedge clk_24);
		menu = 1'b1;
		@(negedge clk_24);
		menu = 1'b0;
		bus_read(ADDR_MENU, d);
		u_tb_checker.value_check("menu_read", 24'hFF, {16'd0, d});
		bus_read(ADDR_IN0, d);
		// low nibble holds id, menu and debug
		u_tb_checker.value_check("in0_id_menu", 24'h0A, {20'd0, d[3:0]});
		bus_write(ADDR_MENU, 8'h00);
		bus_read(ADDR_MENU, d);
		u_tb_checker.value_check("menu_clear", 24'h00, {16'd0, d});

		// pause trigger holds the lfsr at its seed for the whole frame
		bus_write(ADDR_PAUSE, 8'h00);
		capture_frame();
		if (count_diffs() == 0)
			u_tb_checker.note_failure("paused frame matches the running starfield");
		lit = 24'd0;
		lit_n = 0;
		for (int i = 0; i < FRAME; i++)
		begin
			if (frame_cur[i] !== 24'd0)
			begin
				if (lit_n == 0)
					lit = frame_cur[i];
				else if (frame_cur[i] !== lit)
					u_tb_checker.value_check("pause_frozen", lit, frame_cur[i]);
				lit_n++;
			end
		end
		if (lit_n == 0)
			u_tb_checker.note_failure("paused frame shows no star pixels");
		// pause input clears the trigger, stars run again
		@(negedge clk_24);
		pause = 1'b1;
		@(negedge clk_24);
		pause = 1'b0;
		capture_frame();
		if (count_diffs() != 0)
			u_tb_checker.note_failure("starfield still differs after pause cleared");
		u_tb_checker.finish_test("triggers_status");

		// timer restart and count
		bus_write({ADDR_TIMER_PAGE, 8'h00}, 8'h00);
		repeat (TIMER_N * TDIV) @(negedge clk_24);
		bus_read({ADDR_TIMER_PAGE, 8'h00}, d);
		bus_read({ADDR_TIMER_PAGE, 8'h01}, hi_byte);
		u_tb_checker.range_check("timer", TIMER_N - 1, TIMER_N + 1, int'({hi_byte, d}));
		u_tb_checker.finish_test("timer");

		u_tb_checker.summary();
		if (u_tb_checker.errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// hard limit on the run length
	always @(posedge clk_24)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("ERROR timeout, run went past %0d cycles", LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

// File: tb.f
src/aznable_pkg.sv
src/raster_timer.sv
src/bus_regs.sv
src/starfield_layer.sv
src/layer_mixer.sv
src/aznable_video_core.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
